/* dv/uart_tb.sv */
`timescale 1ns/1ps

module uart_tb;
    import uart_pkg::*;

    localparam logic [div_width-1:0] tb_default_div = 16'd8;

    logic                  clk;
    logic                  rst_n;
    logic                  reg_wr;
    logic                  reg_rd;
    reg_addr_t             reg_addr;
    logic [data_width-1:0] reg_wdata;
    logic [data_width-1:0] reg_rdata;
    logic                  rx;
    logic                  tx;
    int                    pass_cnt = 0;
    int                    fail_cnt = 0;
    int                    test_errs = 0;
    int                    cur_div;

    uart_top #(
        .default_div (tb_default_div)
    ) uart_top_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .reg_wr    (reg_wr),
        .reg_rd    (reg_rd),
        .reg_addr  (reg_addr),
        .reg_wdata (reg_wdata),
        .reg_rdata (reg_rdata),
        .rx        (rx),
        .tx        (tx)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // start bit in f[0], data lsb first, stop bit in f[9]
    function automatic logic [9:0] expected_frame(input logic [7:0] b);
        logic [9:0] f;
        f[0] = 1'b0;
        for (int i = 0; i < 8; i++) begin
            f[i+1] = b[i];
        end
        f[9] = 1'b1;
        return f;
    endfunction

    task automatic check_eq(input string name, input int expected, input int actual);
        if (actual != expected) begin
            $display("CHECK FAILED %s expected %0h actual %0h", name, expected, actual);
            fail_cnt++;
            test_errs++;
        end else begin
            pass_cnt++;
        end
    endtask

    task automatic note_failure(input string msg);
        $display("%s", msg);
        fail_cnt++;
        test_errs++;
    endtask

    task automatic finish_test(input string name);
        if (test_errs == 0) begin
            $display("test %s done, no errors", name);
        end else begin
            $display("test %s done, %0d errors", name, test_errs);
        end
        test_errs = 0;
    endtask

    task automatic reg_write(input reg_addr_t a, input logic [7:0] d);
        @(posedge clk);
        reg_wr    <= 1'b1;
        reg_addr  <= a;
        reg_wdata <= d;
        @(posedge clk);
        reg_wr <= 1'b0;
    endtask

    // read data settles after the capture edge and is sampled on the falling edge
    task automatic reg_read(input reg_addr_t a, output logic [7:0] d);
        @(posedge clk);
        reg_rd   <= 1'b1;
        reg_addr <= a;
        @(posedge clk);
        reg_rd <= 1'b0;
        @(negedge clk);
        d = reg_rdata;
    endtask

    task automatic wait_status(input int bitpos, input logic value, input string what,
                               output logic [7:0] st);
        int n;
        n = 0;
        reg_read(addr_status, st);
        while (st[bitpos] !== value && n < 30 * cur_div) begin
            reg_read(addr_status, st);
            n++;
        end
        if (st[bitpos] !== value) begin
            $display("timeout: status bit %0d never became %0b during %s", bitpos, value, what);
            fail_cnt++;
            test_errs++;
        end
    endtask

    task automatic serial_send(input logic [7:0] b, input logic stop_bit);
        logic [9:0] f;
        f    = expected_frame(b);
        f[9] = stop_bit;
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            rx <= f[i];
            repeat (cur_div - 1) @(posedge clk);
        end
        @(posedge clk);
        rx <= 1'b1;
    endtask

    task automatic serial_capture(output logic [9:0] f, output bit ok);
        int n;
        n  = 0;
        ok = 1'b0;
        f  = '0;
        @(negedge clk);
        while (tx !== 1'b0 && n < 20 * cur_div) begin
            @(negedge clk);
            n++;
        end
        if (tx !== 1'b0) begin
            note_failure("timeout: no start bit appeared on tx");
        end else begin
            // move to mid-bit and then sample once per bit period
            repeat (cur_div / 2) @(negedge clk);
            f[0] = tx;
            for (int i = 1; i < 10; i++) begin
                repeat (cur_div) @(negedge clk);
                f[i] = tx;
            end
            ok = 1'b1;
        end
    endtask

    initial begin
        logic [7:0] st;
        logic [7:0] b;
        logic [7:0] b2;
        logic [9:0] frame;
        bit         ok;
        int         extra;
        void'($urandom(5366));
        rst_n     = 1'b0;
        reg_wr    = 1'b0;
        reg_rd    = 1'b0;
        reg_addr  = addr_div_lo;
        reg_wdata = '0;
        rx        = 1'b1;
        cur_div   = tb_default_div;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;

        check_eq("reset tx", 1, tx);
        reg_read(addr_status, st);
        check_eq("reset status", 0, st);
        reg_read(addr_div_lo, st);
        check_eq("reset div_lo", tb_default_div[7:0], st);
        reg_read(addr_div_hi, st);
        check_eq("reset div_hi", tb_default_div[15:8], st);
        finish_test("reset");

        // always above the reset divisor so the new rate shows on the line
        cur_div = 9 + ($urandom % 8);
        reg_write(addr_div_lo, cur_div[7:0]);
        reg_write(addr_div_hi, cur_div[15:8]);
        reg_read(addr_div_lo, st);
        check_eq("divisor readback", cur_div[7:0], st);
        for (int k = 0; k < 4; k++) begin
            b = $urandom;
            fork
                begin
                    serial_capture(frame, ok);
                    if (ok) begin
                        check_eq("tx frame", expected_frame(b), frame);
                    end
                end
                begin
                    reg_write(addr_data, b);
                    reg_read(addr_status, st);
                    check_eq("tx busy in frame", 1, st[bit_tx_busy]);
                    // transmitter still busy so this write is dropped
                    reg_write(addr_data, ~b);
                end
            join
            wait_status(bit_tx_busy, 1'b0, "transmit", st);
            check_eq("status after frame", 0, st);
            extra = 0;
            for (int i = 0; i < 12 * cur_div; i++) begin
                @(negedge clk);
                if (tx !== 1'b1) begin
                    extra = 1;
                end
            end
            if (extra != 0) begin
                note_failure("transmit: extra frame on tx after a write while busy");
            end
        end
        finish_test("transmit");

        for (int k = 0; k < 4; k++) begin
            b = $urandom;
            serial_send(b, 1'b1);
            wait_status(bit_rx_valid, 1'b1, "receive", st);
            reg_read(addr_data, st);
            check_eq("rx data", b, st);
            reg_read(addr_status, st);
            check_eq("status after data read", 0, st);
        end
        finish_test("receive");

        b = $urandom;
        serial_send(b, 1'b0);
        wait_status(bit_framing_error, 1'b1, "framing error", st);
        check_eq("framing rx_valid", 0, st[bit_rx_valid]);
        reg_read(addr_status, st);
        check_eq("framing flag cleared", 0, st[bit_framing_error]);
        finish_test("framing");

        b  = $urandom;
        b2 = $urandom;
        // two different bytes tell which one the data register kept
        if (b2 == b) begin
            b2 = ~b;
        end
        serial_send(b, 1'b1);
        serial_send(b2, 1'b1);
        wait_status(bit_overrun, 1'b1, "overrun", st);
        check_eq("overrun status", 8'h09, st);
        reg_read(addr_data, st);
        check_eq("overrun data", b2, st);
        finish_test("overrun");

        // pin held low so only the internal line can deliver the byte
        reg_write(addr_status, 8'h10);
        @(posedge clk);
        rx <= 1'b0;
        b = $urandom;
        reg_write(addr_data, b);
        wait_status(bit_rx_valid, 1'b1, "loopback", st);
        reg_read(addr_data, st);
        check_eq("loopback data", b, st);
        reg_read(addr_status, st);
        check_eq("loopback rx_valid", 0, st[bit_rx_valid]);
        check_eq("loopback flag", 1, st[bit_loopback]);
        @(posedge clk);
        rx <= 1'b1;
        reg_write(addr_status, 8'h00);
        finish_test("loopback");

        $display("checks passed %0d, checks with errors %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* sim.f */
source/uart_pkg.sv
source/uart_regs.sv
source/uart_rx.sv
source/uart_tx.sv
source/uart_top.sv
dv/uart_tb.sv

/* source/uart_pkg.sv */
package uart_pkg;

    // clocks-per-bit divisor and character widths
    localparam int div_width  = 16;
    localparam int data_width = 8;

    // shorter bit periods leave no room for the half-period start check
    localparam logic [div_width-1:0] div_min = 16'd4;

    typedef enum logic [1:0] {
        addr_div_lo = 2'd0,  // divisor low byte
        addr_div_hi = 2'd1,  // divisor high byte
        addr_data   = 2'd2,  // tx on write, rx byte on read
        addr_status = 2'd3   // flags on read, loopback on write
    } reg_addr_t;

    // status byte layout
    localparam int bit_rx_valid      = 0;
    localparam int bit_tx_busy       = 1;
    localparam int bit_framing_error = 2;
    localparam int bit_overrun       = 3;
    localparam int bit_loopback      = 4;

    typedef enum logic [1:0] {rx_idle, rx_start, rx_data, rx_stop} rx_state_t;

    typedef enum logic [1:0] {tx_idle, tx_start, tx_data, tx_stop} tx_state_t;

endpackage

/* source/uart_regs.sv */
`timescale 1ns/1ps

module uart_regs #(
    parameter logic [uart_pkg::div_width-1:0] default_div = 16'd434
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            reg_wr,
    input  logic                            reg_rd,
    input  uart_pkg::reg_addr_t             reg_addr,
    input  logic [uart_pkg::data_width-1:0] reg_wdata,
    input  logic                            tx_busy,
    input  logic                            rx_done,
    input  logic [uart_pkg::data_width-1:0] rx_byte,
    input  logic                            rx_frame_err,
    output logic [uart_pkg::data_width-1:0] reg_rdata,
    output logic [uart_pkg::div_width-1:0]  div,
    output logic                            tx_start,
    output logic [uart_pkg::data_width-1:0] tx_data,
    output logic                            loopback
);
    import uart_pkg::*;

    logic [div_width-1:0]  div_reg;
    logic [data_width-1:0] rx_data;
    logic                  rx_valid;
    logic                  framing_error;
    logic                  overrun;
    logic [data_width-1:0] status;
    logic [data_width-1:0] rd_mux;
    logic                  data_rd;
    logic                  status_rd;

    assign data_rd   = reg_rd && (reg_addr == addr_data);
    assign status_rd = reg_rd && (reg_addr == addr_status);

    // a data write launches a frame only while the transmitter is idle
    assign tx_start = reg_wr && (reg_addr == addr_data) && !tx_busy;
    assign tx_data  = reg_wdata;

    // clamp to the shortest usable bit period
    assign div = (div_reg < div_min) ? div_min : div_reg;

    always_comb begin
        status                    = '0;
        status[bit_rx_valid]      = rx_valid;
        status[bit_tx_busy]       = tx_busy;
        status[bit_framing_error] = framing_error;
        status[bit_overrun]       = overrun;
        status[bit_loopback]      = loopback;
    end

    always_comb begin
        case (reg_addr)
            addr_div_lo: rd_mux = div_reg[data_width-1:0];
            addr_div_hi: rd_mux = div_reg[div_width-1:data_width];
            addr_data:   rd_mux = rx_data;
            addr_status: rd_mux = status;
            default:     rd_mux = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            div_reg       <= default_div;
            rx_valid      <= 1'b0;
            framing_error <= 1'b0;
            overrun       <= 1'b0;
            loopback      <= 1'b0;
        end else begin
            if (reg_wr) begin
                case (reg_addr)
                    addr_div_lo: div_reg[data_width-1:0] <= reg_wdata;
                    addr_div_hi: div_reg[div_width-1:data_width] <= reg_wdata;
                    addr_status: loopback <= reg_wdata[bit_loopback];
                    default: ;
                endcase
            end
            // reads clear, fresh events below take priority
            if (data_rd) begin
                rx_valid <= 1'b0;
            end
            if (status_rd) begin
                framing_error <= 1'b0;
                overrun       <= 1'b0;
            end
            if (rx_done) begin
                rx_valid <= 1'b1;
                // unread byte about to be replaced
                if (rx_valid && !data_rd) begin
                    overrun <= 1'b1;
                end
            end
            if (rx_frame_err) begin
                framing_error <= 1'b1;
            end
        end
    end

    // receive holding register and read data
    always_ff @(posedge clk) begin
        if (rx_done) begin
            rx_data <= rx_byte;
        end
        if (reg_rd) begin
            reg_rdata <= rd_mux;
        end
    end

endmodule

/* source/uart_rx.sv */
`timescale 1ns/1ps

module uart_rx (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic [uart_pkg::div_width-1:0]  div,
    input  logic                            rx,
    input  logic                            loop_in,
    input  logic                            loopback,
    output logic                            rx_done,
    output logic [uart_pkg::data_width-1:0] rx_byte,
    output logic                            rx_frame_err
);
    import uart_pkg::*;

    rx_state_t                     state;
    logic [div_width-1:0]          cnt;
    logic [$clog2(data_width)-1:0] bit_idx;
    logic [data_width-1:0]         shreg;
    logic                          line_sel;
    logic                          sync_a;
    logic                          line_s;
    logic                          line_prev;
    logic                          fall;
    logic                          wait_done;
    logic                          sample;

    // loopback listens to our own transmitter
    assign line_sel = loopback ? loop_in : rx;

    // two-flop synchronizer plus previous sample for edge detect
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sync_a    <= 1'b1;
            line_s    <= 1'b1;
            line_prev <= 1'b1;
        end else begin
            sync_a    <= line_sel;
            line_s    <= sync_a;
            line_prev <= line_s;
        end
    end

    assign fall      = line_prev && !line_s;
    assign wait_done = (cnt == '0);
    assign sample    = (state == rx_data) && wait_done;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= rx_idle;
            cnt          <= '0;
            bit_idx      <= '0;
            rx_done      <= 1'b0;
            rx_frame_err <= 1'b0;
        end else begin
            rx_done      <= 1'b0;
            rx_frame_err <= 1'b0;
            case (state)
                rx_idle: begin
                    if (fall) begin
                        state <= rx_start;
                        // land in the middle of the start bit
                        cnt   <= (div >> 1) - 1'b1;
                    end
                end
                rx_start: begin
                    if (!wait_done) begin
                        cnt <= cnt - 1'b1;
                    end else if (!line_s) begin
                        state   <= rx_data;
                        cnt     <= div - 1'b1;
                        bit_idx <= '0;
                    end else begin
                        // glitch, not a start bit
                        state <= rx_idle;
                    end
                end
                rx_data: begin
                    if (!wait_done) begin
                        cnt <= cnt - 1'b1;
                    end else begin
                        cnt     <= div - 1'b1;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == ($clog2(data_width))'(data_width - 1)) begin
                            state <= rx_stop;
                        end
                    end
                end
                rx_stop: begin
                    if (!wait_done) begin
                        cnt <= cnt - 1'b1;
                    end else begin
                        rx_done      <= line_s;
                        rx_frame_err <= !line_s;
                        state        <= rx_idle;
                    end
                end
                default: state <= rx_idle;
            endcase
        end
    end

    // lsb arrives first
    always_ff @(posedge clk) begin
        if (sample) begin
            shreg <= {line_s, shreg[data_width-1:1]};
        end
    end

    assign rx_byte = shreg;

endmodule

/* source/uart_top.sv */
`timescale 1ns/1ps

module uart_top #(
    parameter logic [uart_pkg::div_width-1:0] default_div = 16'd434
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            reg_wr,
    input  logic                            reg_rd,
    input  uart_pkg::reg_addr_t             reg_addr,
    input  logic [uart_pkg::data_width-1:0] reg_wdata,
    output logic [uart_pkg::data_width-1:0] reg_rdata,
    input  logic                            rx,
    output logic                            tx
);

    logic [uart_pkg::div_width-1:0]  div;
    logic                            tx_start;
    logic [uart_pkg::data_width-1:0] tx_data;
    logic                            tx_busy;
    logic                            loopback;
    logic                            rx_done;
    logic [uart_pkg::data_width-1:0] rx_byte;
    logic                            rx_frame_err;

    uart_regs #(
        .default_div (default_div)
    ) uart_regs_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .reg_wr       (reg_wr),
        .reg_rd       (reg_rd),
        .reg_addr     (reg_addr),
        .reg_wdata    (reg_wdata),
        .tx_busy      (tx_busy),
        .rx_done      (rx_done),
        .rx_byte      (rx_byte),
        .rx_frame_err (rx_frame_err),
        .reg_rdata    (reg_rdata),
        .div          (div),
        .tx_start     (tx_start),
        .tx_data      (tx_data),
        .loopback     (loopback)
    );

    uart_tx uart_tx_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .div      (div),
        .tx_start (tx_start),
        .tx_data  (tx_data),
        .tx       (tx),
        .tx_busy  (tx_busy)
    );

    // receiver taps the tx pin for loopback
    uart_rx uart_rx_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .div          (div),
        .rx           (rx),
        .loop_in      (tx),
        .loopback     (loopback),
        .rx_done      (rx_done),
        .rx_byte      (rx_byte),
        .rx_frame_err (rx_frame_err)
    );

endmodule

/* source/uart_tx.sv */
`timescale 1ns/1ps

module uart_tx (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic [uart_pkg::div_width-1:0]  div,
    input  logic                            tx_start,
    input  logic [uart_pkg::data_width-1:0] tx_data,
    output logic                            tx,
    output logic                            tx_busy
);
    import uart_pkg::*;

    // tx_start and tx_data name ports here, so those states are scoped
    tx_state_t                     state;
    logic [div_width-1:0]          cnt;
    logic [$clog2(data_width)-1:0] bit_idx;
    logic [data_width-1:0]         shreg;
    logic                          bit_end;
    logic                          shift;

    assign bit_end = (cnt == '0);
    assign shift   = bit_end && (state == uart_pkg::tx_start || state == uart_pkg::tx_data);
    assign tx_busy = (state != tx_idle);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= tx_idle;
            cnt     <= '0;
            bit_idx <= '0;
            tx      <= 1'b1;
        end else begin
            case (state)
                tx_idle: begin
                    if (tx_start) begin
                        state <= uart_pkg::tx_start;
                        cnt   <= div - 1'b1;
                        tx    <= 1'b0;
                    end
                end
                uart_pkg::tx_start: begin
                    if (bit_end) begin
                        state   <= uart_pkg::tx_data;
                        cnt     <= div - 1'b1;
                        bit_idx <= '0;
                        tx      <= shreg[0];
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                uart_pkg::tx_data: begin
                    if (!bit_end) begin
                        cnt <= cnt - 1'b1;
                    end else if (bit_idx == ($clog2(data_width))'(data_width - 1)) begin
                        state <= tx_stop;
                        cnt   <= div - 1'b1;
                        tx    <= 1'b1;
                    end else begin
                        cnt     <= div - 1'b1;
                        bit_idx <= bit_idx + 1'b1;
                        tx      <= shreg[0];
                    end
                end
                tx_stop: begin
                    if (bit_end) begin
                        state <= tx_idle;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                default: state <= tx_idle;
            endcase
        end
    end

    // next data bit always sits in bit 0
    always_ff @(posedge clk) begin
        if (state == tx_idle && tx_start) begin
            shreg <= tx_data;
        end else if (shift) begin
            shreg <= shreg >> 1;
        end
    end

endmodule
